/* mipsCore.f */
logic/mipsCorePkg.sv
logic/fetchUnit.sv
logic/decodeUnit.sv
logic/registerFile.sv
logic/hazardUnit.sv
logic/executeUnit.sv
logic/mipsCore.sv
verification/tbMemory.sv
verification/mipsCoreTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the mipsCore testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    --top-module mipsCoreTb \
    -f mipsCore.f \
    --Mdir obj_dir -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test completed successfully$" sim.log; then
    exit 0
fi
exit 1

/* verification/mipsCoreTb.sv */
module mipsCoreTb
    import mipsCorePkg::*;
();

    localparam int ClkPeriod = 40;
    localparam int NumTests = 6;
    localparam int CyclesPerTest = 400;

    logic clk = 1'b0;
    logic arstN = 1'b0;
    logic instStall = 1'b0;
    logic dataStall = 1'b0;
    logic stallOn = 1'b0;
    logic [31:0] lfsrState = 32'hd1fc_359b;
    logic [XLEN-1:0] instAddr, instData, dataAddr, dataWdata, dataRdata;
    logic [XLEN-1:0] debugPc, debugWdata;
    logic [RegAddrW-1:0] debugWnum;
    logic instEn, dataEn, dataWe, debugWen;

    logic [31:0] retPc[$], retNum[$], retData[$], wrAddr[$], wrData[$];
    logic [31:0] expPc[$], expNum[$], expData[$], expWrAddr[$], expWrData[$];
    int progLen, testErrors, errorCount, failedTests;

    mipsCore dut (
        .clk(clk), .arstN_i(arstN), .instAddr_o(instAddr), .instEn_o(instEn),
        .instData_i(instData), .instStall_i(instStall), .dataEn_o(dataEn),
        .dataWe_o(dataWe), .dataAddr_o(dataAddr), .dataWdata_o(dataWdata),
        .dataRdata_i(dataRdata), .dataStall_i(dataStall), .debugPc_o(debugPc),
        .debugWen_o(debugWen), .debugWnum_o(debugWnum), .debugWdata_o(debugWdata)
    );

    tbMemory mem (
        .clk(clk), .instAddr_i(instAddr), .instEn_i(instEn), .instData_o(instData),
        .dataEn_i(dataEn), .dataWe_i(dataWe), .dataAddr_i(dataAddr),
        .dataWdata_i(dataWdata), .dataRdata_o(dataRdata), .dataStall_i(dataStall)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic nextBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    always @(posedge clk) begin
        #2;
        if (stallOn) begin
            instStall = nextBit() & nextBit();  // about one cycle in four each
            dataStall = nextBit() & nextBit();
        end else begin
            instStall = 1'b0;
            dataStall = 1'b0;
        end
    end

    // sampled mid-cycle, so stalls and outputs have settled
    always @(negedge clk) begin
        if (arstN) begin
            if (debugWen) begin
                retPc.push_back(debugPc);
                retNum.push_back(32'(debugWnum));
                retData.push_back(debugWdata);
            end
            if (dataEn && dataWe && !dataStall && !instStall) begin
                wrAddr.push_back(dataAddr);
                wrData.push_back(dataWdata);
            end
        end
    end

    initial begin
        #((NumTests + 1) * CyclesPerTest * ClkPeriod);
        $display("watchdog: the run took longer than all tests together may take");
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] encR(input int rs, rt, rd, shamt, input functE fn);
        return {OpSpecial, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), fn};
    endfunction

    function automatic logic [31:0] encI(input opcodeE op, input int rs, rt,
                                         input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] pcAt(input int idx);
        return ResetVector + 32'(idx * 4);
    endfunction

    function automatic logic [31:0] encJ(input int targetIdx);
        logic [31:0] target;
        target = pcAt(targetIdx);
        return {OpJ, target[27:2]};
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expVal, actVal);
        if (expVal !== actVal) begin
            $display("[FAIL] %s expected %h actual %h", what, expVal, actVal);
            testErrors++;
        end
    endtask

    task automatic put(input logic [31:0] word);
        mem.rom[progLen] = word;
        progLen++;
    endtask

    task automatic expectRetire(input int idx, input int rd, input logic [31:0] value);
        expPc.push_back(pcAt(idx));
        expNum.push_back(32'(rd));
        expData.push_back(value);
    endtask

    task automatic expectWrite(input logic [31:0] addr, data);
        expWrAddr.push_back(addr);
        expWrData.push_back(data);
    endtask

    task automatic startTest();
        expPc.delete();
        expNum.delete();
        expData.delete();
        expWrAddr.delete();
        expWrData.delete();
        mem.clearRom();
        progLen = 0;
        testErrors = 0;
    endtask

    task automatic endLoop();
        put(encJ(progLen));  // spins on itself, nop in the slot
        put(32'h0);
    endtask

    task automatic compareResults(input string name);
        checkValue({name, " retire count"}, expPc.size(), retPc.size());
        checkValue({name, " write count"}, expWrAddr.size(), wrAddr.size());
        for (int i = 0; i < expPc.size() && i < retPc.size(); i++) begin
            checkValue($sformatf("%s retire %0d pc", name, i), expPc[i], retPc[i]);
            checkValue($sformatf("%s retire %0d wnum", name, i), expNum[i], retNum[i]);
            checkValue($sformatf("%s retire %0d wdata", name, i), expData[i], retData[i]);
        end
        for (int i = 0; i < expWrAddr.size() && i < wrAddr.size(); i++) begin
            checkValue($sformatf("%s write %0d addr", name, i), expWrAddr[i], wrAddr[i]);
            checkValue($sformatf("%s write %0d data", name, i), expWrData[i], wrData[i]);
        end
    endtask

    task automatic runProgram(input string name, input logic withStalls);
        int cycles;
        endLoop();
        mem.fillRam();
        stallOn = 1'b0;
        @(posedge clk);
        #2 arstN = 1'b0;
        repeat (5) @(posedge clk);
        // ports while held in reset
        checkValue({name, " reset fetch address"}, ResetVector, instAddr);
        checkValue({name, " reset instEn"}, 32'd1, 32'(instEn));
        checkValue({name, " reset dataEn dataWe debugWen"}, 32'd0,
                   32'({dataEn, dataWe, debugWen}));
        retPc.delete();
        retNum.delete();
        retData.delete();
        wrAddr.delete();
        wrData.delete();
        stallOn = withStalls;
        #2 arstN = 1'b1;
        cycles = 0;
        while ((retPc.size() < expPc.size() || wrAddr.size() < expWrAddr.size())
               && cycles < CyclesPerTest) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= CyclesPerTest) begin
            $display("%s: the program did not retire everything in time", name);
            testErrors++;
        end
        repeat (16) @(posedge clk);  // room for stray retires to show up
        stallOn = 1'b0;
        compareResults(name);
        if (testErrors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, testErrors);
            failedTests++;
        end
        errorCount += testErrors;
    endtask

    task automatic aluTest();
        logic [31:0] r1, r2, r3, r4, r5, r6, r7;
        startTest();
        r1 = 32'h1234;
        r2 = {16'h8000, 16'h0} | 32'h00f0;
        r3 = r2 & 32'h00ff;  // andi zero-extends
        r4 = r1 + r3;
        r5 = r3 - r1;
        r6 = r4 & r5;
        r7 = r4 | r5;
        put(encI(OpAddiu, 0, 1, 16'h1234));
        put(encI(OpLui, 0, 2, 16'h8000));
        put(encI(OpOri, 2, 2, 16'h00f0));
        put(encI(OpAndi, 2, 3, 16'h00ff));
        put(encR(1, 3, 4, 0, FnAddu));
        put(encR(3, 1, 5, 0, FnSubu));
        put(encR(4, 5, 6, 0, FnAnd));
        put(encR(4, 5, 7, 0, FnOr));
        put(encR(6, 7, 8, 0, FnXor));
        put(encR(2, 1, 9, 0, FnSlt));
        put(encR(1, 2, 10, 0, FnSlt));
        put(encR(0, 1, 11, 4, FnSll));
        expectRetire(0, 1, r1);
        expectRetire(1, 2, 32'h8000_0000);
        expectRetire(2, 2, r2);
        expectRetire(3, 3, r3);
        expectRetire(4, 4, r4);
        expectRetire(5, 5, r5);
        expectRetire(6, 6, r6);
        expectRetire(7, 7, r7);
        expectRetire(8, 8, r6 ^ r7);
        expectRetire(9, 9, ($signed(r2) < $signed(r1)) ? 32'd1 : 32'd0);
        expectRetire(10, 10, ($signed(r1) < $signed(r2)) ? 32'd1 : 32'd0);
        expectRetire(11, 11, r1 << 4);
        runProgram("alu", 1'b0);
    endtask

    task automatic loadStoreTest(input string name, input logic withStalls);
        logic [31:0] base, r2, r3, r5;
        startTest();
        base = 32'h100;
        r2 = 32'h5a5;
        r3 = 32'hcafe_beef;
        r5 = r3 + r2;
        put(encI(OpAddiu, 0, 1, 16'h0100));
        put(encI(OpAddiu, 0, 2, 16'h05a5));
        put(encI(OpLui, 0, 3, 16'hcafe));
        put(encI(OpOri, 3, 3, 16'hbeef));
        put(encI(OpSw, 1, 2, 16'd0));
        put(encI(OpSw, 1, 3, 16'd4));
        put(encI(OpLw, 1, 4, 16'd4));
        put(encR(4, 2, 5, 0, FnAddu));  // needs the load right away
        put(encI(OpSw, 1, 5, 16'd8));
        put(encI(OpLw, 1, 6, 16'd0));
        put(encR(0, 6, 7, 0, FnSubu));
        put(encI(OpLw, 1, 8, 16'd8));
        put(encI(OpSw, 1, 8, 16'd12));  // store data from the load
        expectRetire(0, 1, base);
        expectRetire(1, 2, r2);
        expectRetire(2, 3, 32'hcafe_0000);
        expectRetire(3, 3, r3);
        expectRetire(6, 4, r3);
        expectRetire(7, 5, r5);
        expectRetire(9, 6, r2);
        expectRetire(10, 7, 32'd0 - r2);
        expectRetire(11, 8, r5);
        expectWrite(base, r2);
        expectWrite(base + 4, r3);
        expectWrite(base + 8, r5);
        expectWrite(base + 12, r5);
        runProgram(name, withStalls);
    endtask

    task automatic branchTest();
        startTest();
        put(encI(OpAddiu, 0, 1, 16'd5));
        put(encI(OpAddiu, 0, 2, 16'd5));
        put(encI(OpBeq, 1, 2, 16'd3));  // to index 6
        put(encI(OpAddiu, 0, 3, 16'd1));
        put(encI(OpAddiu, 0, 4, 16'h44));  // squashed
        put(encI(OpAddiu, 0, 4, 16'h55));
        put(encI(OpBeq, 1, 0, 16'd2));  // not taken
        put(encI(OpAddiu, 0, 5, 16'd7));
        put(encI(OpAddiu, 0, 6, 16'd8));
        put(encI(OpBne, 1, 0, 16'd2));  // to index 12
        put(encI(OpAddiu, 0, 7, 16'd9));
        put(encI(OpAddiu, 0, 8, 16'h99));
        put(encI(OpAddiu, 0, 9, 16'h77));
        expectRetire(0, 1, 32'd5);
        expectRetire(1, 2, 32'd5);
        expectRetire(3, 3, 32'd1);
        expectRetire(7, 5, 32'd7);
        expectRetire(8, 6, 32'd8);
        expectRetire(10, 7, 32'd9);
        expectRetire(12, 9, 32'h77);
        runProgram("branch", 1'b0);
    endtask

    task automatic jumpTest();
        startTest();
        put(encI(OpAddiu, 0, 1, 16'd1));
        put(encJ(5));
        put(encI(OpAddiu, 0, 2, 16'd2));  // delay slot
        put(encI(OpAddiu, 0, 3, 16'd3));
        put(encI(OpAddiu, 0, 4, 16'd4));
        put(encI(OpAddiu, 0, 5, 16'd5));
        put(encR(5, 2, 6, 0, FnAddu));
        expectRetire(0, 1, 32'd1);
        expectRetire(2, 2, 32'd2);
        expectRetire(5, 5, 32'd5);
        expectRetire(6, 6, 32'd7);
        runProgram("jump", 1'b0);
    endtask

    task automatic zeroRegTest();
        startTest();
        put(encI(OpAddiu, 0, 0, 16'h0123));
        put(encR(0, 0, 1, 0, FnAddu));
        put(encI(OpAddiu, 0, 2, 16'h0010));
        put(encR(2, 2, 0, 0, FnOr));
        put(encR(0, 2, 3, 0, FnAddu));
        expectRetire(1, 1, 32'd0);
        expectRetire(2, 2, 32'h10);
        expectRetire(4, 3, 32'h10);
        runProgram("zero register", 1'b0);
    endtask

    initial begin
        errorCount = 0;
        failedTests = 0;
        aluTest();
        loadStoreTest("load store", 1'b0);
        branchTest();
        jumpTest();
        loadStoreTest("cache stalls", 1'b1);
        zeroRegTest();
        $display("%0d tests, %0d failed, %0d check errors", NumTests, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verification/tbMemory.sv */
module tbMemory
    import mipsCorePkg::*;
(
    input  logic            clk,
    input  logic [XLEN-1:0] instAddr_i,
    input  logic            instEn_i,
    output logic [XLEN-1:0] instData_o,
    input  logic            dataEn_i,
    input  logic            dataWe_i,
    input  logic [XLEN-1:0] dataAddr_i,
    input  logic [XLEN-1:0] dataWdata_i,
    output logic [XLEN-1:0] dataRdata_o,
    input  logic            dataStall_i
);

    localparam int RomWords = 64;
    localparam int RamWords = 64;

    logic [XLEN-1:0] rom [RomWords];  // program image at ResetVector
    logic [XLEN-1:0] ram [RamWords];
    logic [XLEN-1:0] romOffset;

    task automatic clearRom();
        for (int i = 0; i < RomWords; i++) begin
            rom[i] = '0;  // sll r0, a nop
        end
    endtask

    task automatic fillRam();
        for (int i = 0; i < RamWords; i++) begin
            ram[i] = (i * 4) ^ 32'h6b3d_a5c1;  // byte address mixed in
        end
    endtask

    assign romOffset  = instAddr_i - ResetVector;
    assign instData_o = (instEn_i && (romOffset >> 2) < RomWords) ? rom[romOffset[7:2]] : '0;

    // read is combinational, word addressed
    assign dataRdata_o = ram[dataAddr_i[7:2]];

    always @(posedge clk) begin
        if (dataEn_i && dataWe_i && !dataStall_i) begin
            ram[dataAddr_i[7:2]] <= dataWdata_i;
        end
    end

endmodule

/* logic/mipsCore.sv */
module mipsCore
    import mipsCorePkg::*;
(
    input  logic                clk,
    input  logic                arstN_i,
    output logic [XLEN-1:0]     instAddr_o,
    output logic                instEn_o,
    input  logic [XLEN-1:0]     instData_i,
    input  logic                instStall_i,
    output logic                dataEn_o,
    output logic                dataWe_o,
    output logic [XLEN-1:0]     dataAddr_o,
    output logic [XLEN-1:0]     dataWdata_o,
    input  logic [XLEN-1:0]     dataRdata_i,
    input  logic                dataStall_i,
    output logic [XLEN-1:0]     debugPc_o,
    output logic                debugWen_o,
    output logic [RegAddrW-1:0] debugWnum_o,
    output logic [XLEN-1:0]     debugWdata_o
);

    logic [XLEN-1:0]     pcF;
    instrU               fdInstr;
    logic [XLEN-1:0]     fdPc;
    logic                fdValid;

    ctrlT                ctrlD;
    logic [RegAddrW-1:0] rsD, rtD, destD;
    logic [XLEN-1:0]     immD, branchTargetD, jumpTargetD;
    logic [XLEN-1:0]     rsDataD, rtDataD, srcAD, srcBD;
    logic                jumpRawD, jumpD, usesRtD;

    deStageT             de;
    emStageT             em;
    mwStageT             mw;
    logic [XLEN-1:0]     exeResult, memResult;
    logic                branchTakenE;

    logic                stallFd, freezeAll, squashFd, wbWen;
    fwdSelE              fwdA, fwdB;

    assign jumpD   = jumpRawD && fdValid;
    assign usesRtD = !ctrlD.useImm || ctrlD.memWrite;  // R-type, branches, sw

    fetchUnit fetch (
        .clk(clk), .arstN_i(arstN_i), .hold_i(stallFd || freezeAll),
        .branchTaken_i(branchTakenE), .branchTarget_i(de.immediate),
        .jump_i(jumpD), .jumpTarget_i(jumpTargetD), .pc_o(pcF)
    );

    decodeUnit decode (
        .instr_i(fdInstr), .pcPlus4_i(fdPc + 32'd4), .ctrl_o(ctrlD),
        .rs_o(rsD), .rt_o(rtD), .dest_o(destD), .imm_o(immD),
        .branchTarget_o(branchTargetD), .jumpTarget_o(jumpTargetD), .jump_o(jumpRawD)
    );

    registerFile regFile (
        .clk(clk), .arstN_i(arstN_i), .rs_i(rsD), .rt_i(rtD),
        .we_i(wbWen), .wAddr_i(mw.dest), .wData_i(mw.result),
        .rsData_o(rsDataD), .rtData_o(rtDataD)
    );

    hazardUnit hazard (
        .rsD_i(rsD), .rtD_i(rtD), .usesRtD_i(usesRtD),
        .de_i(de), .em_i(em), .mw_i(mw), .branchTaken_i(branchTakenE),
        .instStall_i(instStall_i), .dataStall_i(dataStall_i),
        .stallFd_o(stallFd), .freezeAll_o(freezeAll), .squashFd_o(squashFd),
        .fwdA_o(fwdA), .fwdB_o(fwdB)
    );

    executeUnit execute (.de_i(de), .result_o(exeResult), .branchTaken_o(branchTakenE));

    // load data arrives in the memory stage
    assign memResult = em.memRead ? dataRdata_i : em.aluResult;

    function automatic logic [XLEN-1:0] fwdMux(input fwdSelE sel,
                                               input logic [XLEN-1:0] rfData);
        case (sel)
            FwdExe:  return exeResult;
            FwdMem:  return memResult;
            FwdWb:   return mw.result;
            default: return rfData;
        endcase
    endfunction

    always_comb begin
        srcAD = fwdMux(fwdA, rsDataD);
        srcBD = fwdMux(fwdB, rtDataD);
    end

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            fdInstr <= '0;
            fdPc    <= '0;
            fdValid <= 1'b0;
        end else if (!freezeAll) begin
            if (squashFd) begin
                fdInstr <= '0;  // sll r0 bubble
                fdValid <= 1'b0;
            end else if (!stallFd) begin
                fdInstr <= instrU'(instData_i);
                fdPc    <= pcF;
                fdValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            de <= '0;
            em <= '0;
            mw <= '0;
        end else if (!freezeAll) begin
            de.pc        <= fdPc;
            de.srcA      <= srcAD;
            de.srcB      <= srcBD;
            de.storeData <= srcBD;
            de.immediate <= ctrlD.isBranch ? branchTargetD : immD;
            de.shamt     <= fdInstr.rFmt.shamt;
            de.dest      <= destD;
            de.ctrl      <= ctrlD;
            de.valid     <= fdValid && !stallFd;  // bubble on load-use

            em.aluResult <= exeResult;
            em.storeData <= de.storeData;
            em.dest      <= de.dest;
            em.regWrite  <= de.ctrl.regWrite;
            em.memRead   <= de.ctrl.memRead;
            em.memWrite  <= de.ctrl.memWrite;
            em.pc        <= de.pc;
            em.valid     <= de.valid;

            mw.result    <= memResult;
            mw.dest      <= em.dest;
            mw.regWrite  <= em.regWrite;
            mw.pc        <= em.pc;
            mw.valid     <= em.valid;
        end
    end

    assign instAddr_o = pcF;
    assign instEn_o   = !squashFd;  // word after the delay slot is dropped anyway

    // em holds during a freeze, so these stay put
    assign dataEn_o    = em.valid && (em.memRead || em.memWrite);
    assign dataWe_o    = em.valid && em.memWrite;
    assign dataAddr_o  = em.aluResult;
    assign dataWdata_o = em.storeData;

    // one retire per instruction, none while frozen
    assign wbWen        = mw.valid && mw.regWrite && mw.dest != '0 && !freezeAll;
    assign debugPc_o    = mw.pc;
    assign debugWen_o   = wbWen;
    assign debugWnum_o  = mw.dest;
    assign debugWdata_o = mw.result;

endmodule

/* logic/executeUnit.sv */
module executeUnit
    import mipsCorePkg::*;
(
    input  deStageT         de_i,
    output logic [XLEN-1:0] result_o,
    output logic            branchTaken_o
);

    logic [XLEN-1:0] opB;
    logic            srcEqual;

    assign opB = de_i.ctrl.useImm ? de_i.immediate : de_i.srcB;

    always_comb begin
        case (de_i.ctrl.aluOp)
            AluAdd:  result_o = de_i.srcA + opB;  // also lw/sw address
            AluSub:  result_o = de_i.srcA - opB;
            AluAnd:  result_o = de_i.srcA & opB;
            AluOr:   result_o = de_i.srcA | opB;
            AluXor:  result_o = de_i.srcA ^ opB;
            AluSlt:  result_o = {{(XLEN-1){1'b0}}, $signed(de_i.srcA) < $signed(opB)};
            AluSll:  result_o = opB << de_i.shamt;
            AluLui:  result_o = {opB[15:0], 16'b0};
            default: result_o = '0;
        endcase
    end

    assign srcEqual = (de_i.srcA == de_i.srcB);

    // bne inverts the compare
    assign branchTaken_o = de_i.valid && de_i.ctrl.isBranch &&
                           (srcEqual != de_i.ctrl.branchNe);

endmodule

/* logic/hazardUnit.sv */
module hazardUnit
    import mipsCorePkg::*;
(
    input  logic [RegAddrW-1:0] rsD_i,
    input  logic [RegAddrW-1:0] rtD_i,
    input  logic                usesRtD_i,
    input  deStageT             de_i,
    input  emStageT             em_i,
    input  mwStageT             mw_i,
    input  logic                branchTaken_i,
    input  logic                instStall_i,
    input  logic                dataStall_i,
    output logic                stallFd_o,
    output logic                freezeAll_o,
    output logic                squashFd_o,
    output fwdSelE              fwdA_o,
    output fwdSelE              fwdB_o
);

    logic exeWrites;
    logic memWrites;
    logic wbWrites;
    logic loadInExe;

    assign exeWrites = de_i.valid && de_i.ctrl.regWrite && de_i.dest != '0;
    assign memWrites = em_i.valid && em_i.regWrite && em_i.dest != '0;
    assign wbWrites  = mw_i.valid && mw_i.regWrite && mw_i.dest != '0;

    // youngest producer wins
    function automatic fwdSelE pickSource(input logic [RegAddrW-1:0] idx);
        return (exeWrites && de_i.dest == idx) ? FwdExe :
               (memWrites && em_i.dest == idx) ? FwdMem :
               (wbWrites  && mw_i.dest == idx) ? FwdWb  : FwdReg;
    endfunction

    always_comb begin
        fwdA_o = pickSource(rsD_i);
        fwdB_o = pickSource(rtD_i);
    end

    // load data only exists from the memory stage on
    assign loadInExe = de_i.valid && de_i.ctrl.memRead && de_i.dest != '0;
    assign stallFd_o = loadInExe &&
                       (de_i.dest == rsD_i || (usesRtD_i && de_i.dest == rtD_i));

    assign freezeAll_o = instStall_i || dataStall_i;  // either cache not ready
    assign squashFd_o  = branchTaken_i;               // drop the word after the delay slot

endmodule

/* logic/registerFile.sv */
module registerFile
    import mipsCorePkg::*;
(
    input  logic                clk,
    input  logic                arstN_i,
    input  logic [RegAddrW-1:0] rs_i,
    input  logic [RegAddrW-1:0] rt_i,
    input  logic                we_i,
    input  logic [RegAddrW-1:0] wAddr_i,
    input  logic [XLEN-1:0]     wData_i,
    output logic [XLEN-1:0]     rsData_o,
    output logic [XLEN-1:0]     rtData_o
);

    logic [XLEN-1:0] regs [2**RegAddrW];  // entry 0 is never written

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < 2**RegAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wAddr_i != '0) begin
            regs[wAddr_i] <= wData_i;
        end
    end

    // writeback value seen by decode in the same cycle
    assign rsData_o = (rs_i == '0) ? '0 :
                      (we_i && wAddr_i == rs_i) ? wData_i : regs[rs_i];
    assign rtData_o = (rt_i == '0) ? '0 :
                      (we_i && wAddr_i == rt_i) ? wData_i : regs[rt_i];

endmodule

/* logic/decodeUnit.sv */
module decodeUnit
    import mipsCorePkg::*;
(
    input  instrU               instr_i,
    input  logic [XLEN-1:0]     pcPlus4_i,
    output ctrlT                ctrl_o,
    output logic [RegAddrW-1:0] rs_o,
    output logic [RegAddrW-1:0] rt_o,
    output logic [RegAddrW-1:0] dest_o,
    output logic [XLEN-1:0]     imm_o,
    output logic [XLEN-1:0]     branchTarget_o,
    output logic [XLEN-1:0]     jumpTarget_o,
    output logic                jump_o
);

    logic zeroExt;  // andi, ori, lui
    logic rdDest;

    always_comb begin
        ctrl_o  = '0;  // anything unknown stays a nop
        zeroExt = 1'b0;
        rdDest  = 1'b0;
        case (instr_i.rFmt.opcode)
            OpSpecial: begin
                rdDest          = 1'b1;
                ctrl_o.regWrite = 1'b1;
                case (instr_i.rFmt.funct)
                    FnSll:   ctrl_o.aluOp = AluSll;
                    FnAddu:  ctrl_o.aluOp = AluAdd;
                    FnSubu:  ctrl_o.aluOp = AluSub;
                    FnAnd:   ctrl_o.aluOp = AluAnd;
                    FnOr:    ctrl_o.aluOp = AluOr;
                    FnXor:   ctrl_o.aluOp = AluXor;
                    FnSlt:   ctrl_o.aluOp = AluSlt;
                    default: ctrl_o.regWrite = 1'b0;
                endcase
            end
            OpAddiu: begin
                ctrl_o.useImm   = 1'b1;
                ctrl_o.regWrite = 1'b1;
            end
            OpAndi, OpOri, OpLui: begin
                zeroExt         = 1'b1;
                ctrl_o.useImm   = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.aluOp    = (instr_i.iFmt.opcode == OpAndi) ? AluAnd :
                                  (instr_i.iFmt.opcode == OpOri)  ? AluOr  : AluLui;
            end
            OpLw: begin
                ctrl_o.useImm   = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.memRead  = 1'b1;
            end
            OpSw: begin
                ctrl_o.useImm   = 1'b1;
                ctrl_o.memWrite = 1'b1;
            end
            OpBeq, OpBne: begin
                ctrl_o.isBranch = 1'b1;
                ctrl_o.branchNe = (instr_i.iFmt.opcode == OpBne);
            end
            OpJ:     ctrl_o.isJump = 1'b1;
            default: ;
        endcase
    end

    assign imm_o = zeroExt ? {16'b0, instr_i.iFmt.imm16}
                           : {{16{instr_i.iFmt.imm16[15]}}, instr_i.iFmt.imm16};

    // rd for register format, rt for the immediate group and lw
    assign dest_o = rdDest ? instr_i.rFmt.rd : instr_i.iFmt.rt;

    // the index of j would alias register fields
    assign rs_o = ctrl_o.isJump ? '0 : instr_i.iFmt.rs;
    assign rt_o = ctrl_o.isJump ? '0 : instr_i.iFmt.rt;

    assign branchTarget_o = pcPlus4_i + {imm_o[XLEN-3:0], 2'b00};
    assign jumpTarget_o   = {pcPlus4_i[XLEN-1:28], instr_i.iFmt.rs, instr_i.iFmt.rt,
                             instr_i.iFmt.imm16, 2'b00};
    assign jump_o         = ctrl_o.isJump;

endmodule

/* logic/fetchUnit.sv */
module fetchUnit
    import mipsCorePkg::*;
(
    input  logic            clk,
    input  logic            arstN_i,
    input  logic            hold_i,
    input  logic            branchTaken_i,
    input  logic [XLEN-1:0] branchTarget_i,
    input  logic            jump_i,
    input  logic [XLEN-1:0] jumpTarget_i,
    output logic [XLEN-1:0] pc_o
);

    logic [XLEN-1:0] pcNext;

    always_comb begin
        if (branchTaken_i) begin
            pcNext = branchTarget_i;  // older instruction, so it goes first
        end else if (jump_i) begin
            pcNext = jumpTarget_i;
        end else begin
            pcNext = pc_o + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            pc_o <= ResetVector;
        end else if (!hold_i) begin
            pc_o <= pcNext;
        end
    end

endmodule

/* logic/mipsCorePkg.sv */
package mipsCorePkg;

    localparam int XLEN = 32;
    localparam int RegAddrW = 5;
    localparam logic [XLEN-1:0] ResetVector = 32'hbfc0_0000;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OpSpecial = 6'b000000,
        OpJ       = 6'b000010,
        OpBeq     = 6'b000100,
        OpBne     = 6'b000101,
        OpAddiu   = 6'b001001,
        OpAndi    = 6'b001100,
        OpOri     = 6'b001101,
        OpLui     = 6'b001111,
        OpLw      = 6'b100011,
        OpSw      = 6'b101011
    } opcodeE;

    typedef enum logic [5:0] {
        FnSll  = 6'b000000,
        FnAddu = 6'b100001,
        FnSubu = 6'b100011,
        FnAnd  = 6'b100100,
        FnOr   = 6'b100101,
        FnXor  = 6'b100110,
        FnSlt  = 6'b101010
    } functE;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOr,
        AluXor, AluSlt, AluSll, AluLui
    } aluOpE;

    typedef enum logic [1:0] {FwdReg, FwdExe, FwdMem, FwdWb} fwdSelE;

    typedef struct packed {
        opcodeE              opcode;
        logic [RegAddrW-1:0] rs;
        logic [RegAddrW-1:0] rt;
        logic [RegAddrW-1:0] rd;
        logic [4:0]          shamt;
        functE               funct;
    } rFmtT;

    typedef struct packed {
        opcodeE              opcode;
        logic [RegAddrW-1:0] rs;
        logic [RegAddrW-1:0] rt;
        logic [15:0]         imm16;
    } iFmtT;

    // one fetched word, seen as register or immediate format
    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
    } instrU;

    typedef struct packed {
        aluOpE aluOp;
        logic  useImm;
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  isBranch;
        logic  branchNe;
        logic  isJump;
    } ctrlT;

    typedef struct packed {
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     srcA;
        logic [XLEN-1:0]     srcB;
        logic [XLEN-1:0]     storeData;
        logic [XLEN-1:0]     immediate;  // branch target for beq/bne
        logic [4:0]          shamt;
        logic [RegAddrW-1:0] dest;
        ctrlT                ctrl;
        logic                valid;
    } deStageT;

    typedef struct packed {
        logic [XLEN-1:0]     aluResult;
        logic [XLEN-1:0]     storeData;
        logic [RegAddrW-1:0] dest;
        logic                regWrite;
        logic                memRead;
        logic                memWrite;
        logic [XLEN-1:0]     pc;
        logic                valid;
    } emStageT;

    typedef struct packed {
        logic [XLEN-1:0]     result;
        logic [RegAddrW-1:0] dest;
        logic                regWrite;
        logic [XLEN-1:0]     pc;
        logic                valid;
    } mwStageT;

endpackage
